/* tb.f */
rtl/autotest_pkg.sv
rtl/header_regs.sv
rtl/run_timer.sv
rtl/tx_byte_sel.sv
rtl/autotest_ctrl.sv
rtl/autotest_top.sv
verif/sd_host_model.sv
verif/tb_autotest.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the log
rm -f sim.log \
    && verilator --binary --timing --assert -Wno-fatal --top-module tb_autotest -f tb.f \
    && ./obj_dir/Vtb_autotest | tee sim.log \
    && grep -q "^Test OK$" sim.log \
    || { echo "simulation did not pass"; exit 1; }

/* verif/tb_autotest.sv */
`default_nettype none

module tb_autotest;
    timeunit 1ns;
    timeprecision 1ps;

    import autotest_pkg::*;

    localparam int TIMEOUT  = 200;
    localparam int N_ITER   = 4;
    localparam int MAX_BUSY = 4;
    localparam int N_BLOCKS = 3;
    // two byte passes per block at worst busy plus every run timing out
    localparam int WATCHDOG_NS =
        2 * N_BLOCKS * (BLOCK_BYTES * 2 * (MAX_BUSY + 3) + N_ITER * (TIMEOUT + 4)) * 10;

    logic        clk;
    logic        rst;
    logic        rst_q = 1'b0;
    logic        sd_busy;
    sd_byte_t    sd_rdata;
    sd_req_t     sd_req;
    sd_byte_t    sd_wdata;
    logic        uut_finish;
    logic        uut_rst;
    logic        uut_start;
    uut_cfg_t    uut_cfg;
    logic        halted;
    logic [3:0]  req_bits;
    logic [1:0]  busy_delay;
    logic [15:0] lfsr;
    logic        start_s;

    sd_byte_t    img       [0:4*BLOCK_BYTES-1];
    uut_cfg_t    cfg_exp   [0:3];
    logic        sig_good  [0:3];
    int          k_plan    [0:4];
    int          time_exp  [0:1][0:3];
    int          slots_exp [0:1];
    int          run_no;
    int          run_edges;
    int          k_now;
    int          errors;

    autotest_top #(
        .MAX_ITER       (N_ITER),
        .TIMEOUT_CYCLES (TIMEOUT)
    ) autotest_top_inst (
        .clk          (clk),
        .rst          (rst),
        .sd_busy_i    (sd_busy),
        .sd_rdata_i   (sd_rdata),
        .sd_req_o     (sd_req),
        .sd_wdata_o   (sd_wdata),
        .uut_finish_i (uut_finish),
        .uut_rst_o    (uut_rst),
        .uut_start_o  (uut_start),
        .uut_cfg_o    (uut_cfg),
        .halted_o     (halted)
    );

    sd_host_model host_inst (
        .clk     (clk),
        .rst     (rst),
        .req_i   (sd_req),
        .wdata_i (sd_wdata),
        .delay_i (busy_delay),
        .busy_o  (sd_busy),
        .rdata_o (sd_rdata)
    );

    assign req_bits = {sd_req.r_block, sd_req.r_byte, sd_req.w_block, sd_req.w_byte};

    always #5 clk = ~clk;

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic put_header(int b, logic [31:0] sig, iter_t iter, logic [15:0] nblk,
                              sd_byte_t sclk, sd_byte_t cmd18);
        int base;
        base = b * BLOCK_BYTES;
        img[base + OFS_SIG]      = sig[31:24];
        img[base + OFS_SIG + 1]  = sig[23:16];
        img[base + OFS_SIG + 2]  = sig[15:8];
        img[base + OFS_SIG + 3]  = sig[7:0];
        img[base + OFS_ITER]     = iter;
        img[base + OFS_NBLK]     = nblk[7:0];
        img[base + OFS_NBLK + 1] = nblk[15:8];
        img[base + OFS_SCLK]     = sclk;
        img[base + OFS_CMD18]    = cmd18;
        cfg_exp[b]  = {nblk, sclk, cmd18};
        sig_good[b] = sig == SIGNATURE;
    endtask

    task automatic check_value(string name, int idx, logic [31:0] exp, logic [31:0] act);
        assert (exp === act)
        else
        begin
            errors++;
            $display("[FAIL] %s [%0d]: expected %0h actual %0h", name, idx, exp, act);
        end
    endtask

    // header echo, run times lsb first, then padding
    task automatic check_written(int b);
        int base;
        int p;
        int i;
        run_time_t got;
        base = b * BLOCK_BYTES;
        for (i = 0; i < OFS_TIMES; i++)
            check_value("echo", base + i, img[base + i], host_inst.wmem[base + i]);
        for (i = 0; i < slots_exp[b]; i++)
        begin
            p   = base + OFS_TIMES + 4 * i;
            got = {host_inst.wmem[p + 3], host_inst.wmem[p + 2],
                   host_inst.wmem[p + 1], host_inst.wmem[p]};
            check_value("run time", b * 4 + i, time_exp[b][i], got);
        end
        for (i = OFS_TIMES + 4 * slots_exp[b]; i < BLOCK_BYTES; i++)
            check_value("padding", base + i, 8'hFF, host_inst.wmem[base + i]);
    endtask

    // new delay bits each cycle with one lfsr step per bit
    always @(posedge clk)
    begin
        #1;
        lfsr = lfsr_next(lfsr);
        busy_delay[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        busy_delay[1] = lfsr[0];
    end

    // uut model raises finish K edges after start unless K is 0
    always @(posedge clk)
    begin
        start_s = uut_start;
        #1;
        if (rst || !start_s)
        begin
            run_edges  = 0;
            uut_finish = 1'b0;
        end
        else
        begin
            if (run_edges == 0)
            begin
                k_now = (run_no < 5) ? k_plan[run_no] : 1;
                if (run_no >= 5)
                begin
                    errors++;
                    $display("unexpected UUT run number %0d was started", run_no);
                end
                run_no++;
            end
            run_edges++;
            if (k_now != 0 && run_edges >= k_now)
                uut_finish = 1'b1;
        end
    end

    always @(posedge clk)
        rst_q <= rst;

    assert property (@(posedge clk) rst_q |->
        (req_bits == 4'b0000 && !uut_start && !halted && uut_rst))
    else
    begin
        errors++;
        $display("[FAIL] reset: expected %s actual req=%b start=%b halted=%b uut_rst=%b",
                 "req=0000 start=0 halted=0 uut_rst=1", $sampled(req_bits),
                 $sampled(uut_start), $sampled(halted), $sampled(uut_rst));
    end

    assert property (@(posedge clk) disable iff (rst)
        uut_start |-> uut_cfg == cfg_exp[sd_req.block_addr[1:0]])
    else
    begin
        errors++;
        $display("[FAIL] config block %0d: expected %h actual %h", $sampled(sd_req.block_addr),
                 cfg_exp[$sampled(sd_req.block_addr[1:0])], $sampled(uut_cfg));
    end

    assert property (@(posedge clk) disable iff (rst)
        uut_start |-> sig_good[sd_req.block_addr[1:0]])
    else
    begin
        errors++;
        $display("UUT was started for block %0d, which has a bad signature",
                 $sampled(sd_req.block_addr));
    end

    assert property (@(posedge clk) disable iff (rst)
        halted |-> !sig_good[sd_req.block_addr[1:0]])
    else
    begin
        errors++;
        $display("sequencer halted on block %0d, which has a valid signature",
                 $sampled(sd_req.block_addr));
    end

    assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else
    begin
        errors++;
        $display("[FAIL] halt sticky: expected 1 actual %b", $sampled(halted));
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the sequencer did not halt within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial
    begin
        clk        = 1'b0;
        rst        = 1'b1;
        uut_finish = 1'b0;
        busy_delay = 2'b00;
        lfsr       = 16'd77;
        run_no     = 0;
        run_edges  = 0;
        k_now      = 0;
        errors     = 0;
        for (int a = 0; a < 4 * BLOCK_BYTES; a++)
            img[a] = sd_byte_t'((a * 37) ^ (a >> 5));
        put_header(0, SIGNATURE, 8'd3, 16'h0123, 8'h10, 8'h01);
        put_header(1, SIGNATURE, 8'd2, 16'h0040, 8'h04, 8'h00);
        put_header(2, 32'hAABBCCDE, 8'd1, 16'h0002, 8'h08, 8'h01);
        put_header(3, 32'h0, 8'd0, 16'h0, 8'h0, 8'h0);
        for (int a = 0; a < 4 * BLOCK_BYTES; a++)
            host_inst.mem[a] = img[a];
        k_plan[0]       = 5;
        k_plan[1]       = 12;
        k_plan[2]       = 30;
        k_plan[3]       = 7;
        k_plan[4]       = 0;
        time_exp[0][0]  = 5;
        time_exp[0][1]  = 12;
        time_exp[0][2]  = 30;
        time_exp[1][0]  = 7;
        time_exp[1][1]  = TIMEOUT;
        slots_exp[0]    = 3;
        slots_exp[1]    = 2;

        repeat (2) @(posedge clk);
        #1 rst = 1'b0;

        wait (halted === 1'b1);
        // observe the halt for a while
        repeat (50) @(posedge clk);

        check_value("read count", 0, 3, host_inst.n_rd);
        for (int i = 0; i < 3; i++)
            check_value("read addr", i, i, host_inst.rd_log[i]);
        check_value("write count", 0, 2, host_inst.n_wr);
        for (int i = 0; i < 2; i++)
            check_value("write addr", i, i, host_inst.wr_log[i]);
        check_value("uut runs", 0, 5, run_no);
        check_value("halted", 0, 1, halted);
        check_written(0);
        check_written(1);

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/sd_host_model.sv */
`default_nettype none

module sd_host_model (
    input  logic                   clk,
    input  logic                   rst,
    input  autotest_pkg::sd_req_t  req_i,
    input  autotest_pkg::sd_byte_t wdata_i,
    input  logic [1:0]             delay_i,
    output logic                   busy_o,
    output autotest_pkg::sd_byte_t rdata_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import autotest_pkg::*;

    // four-block store, picked by the low address bits
    sd_byte_t    mem    [0:4*BLOCK_BYTES-1];
    sd_byte_t    wmem   [0:4*BLOCK_BYTES-1];
    block_addr_t rd_log [0:7];
    block_addr_t wr_log [0:7];
    int          n_rd;
    int          n_wr;

    sd_req_t     req_s;
    sd_byte_t    wdata_s;
    logic [1:0]  delay_s;
    sd_byte_t    wbyte;
    logic        selected;
    logic        writing;
    int          cnt;
    int          base;
    int          idx;

    initial
    begin
        busy_o   = 1'b0;
        rdata_o  = '0;
        selected = 1'b0;
        writing  = 1'b0;
        n_rd     = 0;
        n_wr     = 0;
        cnt      = 0;
        base     = 0;
        idx      = 0;
    end

    always @(posedge clk)
    begin
        req_s   = req_i;
        wdata_s = wdata_i;
        delay_s = delay_i;
        #1;
        if (rst)
        begin
            busy_o   = 1'b0;
            selected = 1'b0;
            cnt      = 0;
        end
        else if (cnt > 0)
        begin
            cnt--;
            // busy drops, read data valid in the same cycle
            if (cnt == 0)
            begin
                busy_o = 1'b0;
                if (!selected)
                    selected = 1'b1;
                else if (writing)
                begin
                    wmem[base + idx] = wbyte;
                    idx++;
                end
                else
                begin
                    rdata_o = mem[base + idx];
                    idx++;
                end
            end
        end
        else if (!selected && (req_s.r_block || req_s.w_block))
        begin
            writing = req_s.w_block;
            base    = int'(req_s.block_addr[1:0]) * BLOCK_BYTES;
            idx     = 0;
            if (writing && n_wr < 8)
                wr_log[n_wr] = req_s.block_addr;
            else if (!writing && n_rd < 8)
                rd_log[n_rd] = req_s.block_addr;
            if (writing)
                n_wr++;
            else
                n_rd++;
            busy_o = 1'b1;
            cnt    = int'(delay_s) + 1;
        end
        else if (selected && !req_s.r_block && !req_s.w_block)
            selected = 1'b0;
        else if (selected && (req_s.r_byte || req_s.w_byte) && idx < BLOCK_BYTES)
        begin
            wbyte  = wdata_s;
            busy_o = 1'b1;
            cnt    = int'(delay_s) + 1;
        end
    end

endmodule

`default_nettype wire

/* rtl/autotest_top.sv */
`default_nettype none

module autotest_top #(
    parameter int START_BLOCK    = autotest_pkg::DEF_START_BLOCK,
    parameter int MAX_ITER       = autotest_pkg::DEF_MAX_ITER,
    parameter int TIMEOUT_CYCLES = autotest_pkg::DEF_TIMEOUT_CYCLES
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sd_busy_i,
    input  autotest_pkg::sd_byte_t sd_rdata_i,
    output autotest_pkg::sd_req_t  sd_req_o,
    output autotest_pkg::sd_byte_t sd_wdata_o,
    input  logic                   uut_finish_i,
    output logic                   uut_rst_o,
    output logic                   uut_start_o,
    output autotest_pkg::uut_cfg_t uut_cfg_o,
    output logic                   halted_o
);
    import autotest_pkg::*;

    hdr_wr_t                    hdr_wr;
    logic                       hdr_clr;
    logic                       sig_ok;
    logic [31:0]                sig;
    iter_t                      iter_count;
    logic                       timer_run;
    logic                       timer_clr;
    iter_t                      iter_idx;
    logic                       run_done;
    run_time_t [MAX_ITER-1:0]   times;
    byte_idx_t                  byte_idx;
    logic                       load_byte;

    autotest_ctrl #(
        .START_BLOCK (START_BLOCK),
        .MAX_ITER    (MAX_ITER)
    ) ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .sd_busy_i    (sd_busy_i),
        .sd_req_o     (sd_req_o),
        .uut_rst_o    (uut_rst_o),
        .uut_start_o  (uut_start_o),
        .halted_o     (halted_o),
        .hdr_wr_o     (hdr_wr),
        .hdr_clr_o    (hdr_clr),
        .sig_ok_i     (sig_ok),
        .iter_count_i (iter_count),
        .timer_run_o  (timer_run),
        .timer_clr_o  (timer_clr),
        .iter_idx_o   (iter_idx),
        .run_done_i   (run_done),
        .byte_idx_o   (byte_idx),
        .load_byte_o  (load_byte)
    );

    header_regs header_regs_inst (
        .clk          (clk),
        .hdr_clr_i    (hdr_clr),
        .hdr_wr_i     (hdr_wr),
        .sd_rdata_i   (sd_rdata_i),
        .sig_o        (sig),
        .iter_count_o (iter_count),
        .uut_cfg_o    (uut_cfg_o),
        .sig_ok_o     (sig_ok)
    );

    run_timer #(
        .MAX_ITER       (MAX_ITER),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) run_timer_inst (
        .clk          (clk),
        .timer_clr_i  (timer_clr),
        .timer_run_i  (timer_run),
        .uut_finish_i (uut_finish_i),
        .iter_idx_i   (iter_idx),
        .run_done_o   (run_done),
        .times_o      (times)
    );

    tx_byte_sel #(
        .MAX_ITER (MAX_ITER)
    ) tx_byte_sel_inst (
        .clk          (clk),
        .load_byte_i  (load_byte),
        .byte_idx_i   (byte_idx),
        .sig_i        (sig),
        .iter_count_i (iter_count),
        .uut_cfg_i    (uut_cfg_o),
        .times_i      (times),
        .sd_wdata_o   (sd_wdata_o)
    );

endmodule

`default_nettype wire

/* rtl/autotest_ctrl.sv */
`default_nettype none

module autotest_ctrl #(
    parameter int START_BLOCK = autotest_pkg::DEF_START_BLOCK,
    parameter int MAX_ITER    = autotest_pkg::DEF_MAX_ITER
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    sd_busy_i,
    output autotest_pkg::sd_req_t   sd_req_o,
    output logic                    uut_rst_o,
    output logic                    uut_start_o,
    output logic                    halted_o,
    output autotest_pkg::hdr_wr_t   hdr_wr_o,
    output logic                    hdr_clr_o,
    input  logic                    sig_ok_i,
    input  autotest_pkg::iter_t     iter_count_i,
    output logic                    timer_run_o,
    output logic                    timer_clr_o,
    output autotest_pkg::iter_t     iter_idx_o,
    input  logic                    run_done_i,
    output autotest_pkg::byte_idx_t byte_idx_o,
    output logic                    load_byte_o
);
    import autotest_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    block_addr_t block_addr;
    byte_idx_t   byte_idx;
    iter_t       iter_idx;
    iter_t       n_runs;
    logic        byte_done;
    logic        last_byte;
    logic        last_run;

    assign n_runs    = run_count(iter_count_i, MAX_ITER);
    assign byte_done = (state == ST_RD_WAIT || state == ST_WR_WAIT) && !sd_busy_i;
    assign last_byte = byte_idx == byte_idx_t'(BLOCK_BYTES - 1);
    assign last_run  = iter_idx == n_runs - 1'b1;

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:     state_nxt = ST_RD_BLOCK;
            ST_RD_BLOCK: if (sd_busy_i) state_nxt = ST_RD_SEL;
            ST_RD_SEL:   if (!sd_busy_i) state_nxt = ST_RD_REQ;
            ST_RD_REQ:   if (sd_busy_i) state_nxt = ST_RD_WAIT;
            ST_RD_WAIT:
                if (!sd_busy_i)
                    state_nxt = last_byte ? ST_CHECK : ST_RD_REQ;
            ST_CHECK:
                if (!sig_ok_i)
                    state_nxt = ST_HALT;
                else if (n_runs == '0)
                    state_nxt = ST_WR_BLOCK;
                else
                    state_nxt = ST_RUN_RST;
            ST_RUN_RST:  state_nxt = ST_RUN;
            ST_RUN:
                if (run_done_i)
                    state_nxt = last_run ? ST_WR_BLOCK : ST_RUN_RST;
            ST_WR_BLOCK: if (sd_busy_i) state_nxt = ST_WR_SEL;
            ST_WR_SEL:   if (!sd_busy_i) state_nxt = ST_WR_LOAD;
            // byte register settles here, w_byte goes up next cycle
            ST_WR_LOAD:  state_nxt = ST_WR_REQ;
            ST_WR_REQ:   if (sd_busy_i) state_nxt = ST_WR_WAIT;
            ST_WR_WAIT:
                if (!sd_busy_i)
                    state_nxt = last_byte ? ST_ADVANCE : ST_WR_LOAD;
            ST_ADVANCE:  state_nxt = ST_IDLE;
            ST_HALT:     state_nxt = ST_HALT;
            default:     state_nxt = ST_IDLE;
        endcase
    end

    always_comb
    begin
        sd_req_o.r_block    = state inside {ST_RD_BLOCK, ST_RD_SEL, ST_RD_REQ, ST_RD_WAIT};
        sd_req_o.r_byte     = state == ST_RD_REQ;
        sd_req_o.w_block    = state inside {ST_WR_BLOCK, ST_WR_SEL, ST_WR_LOAD,
                                            ST_WR_REQ, ST_WR_WAIT};
        sd_req_o.w_byte     = state == ST_WR_REQ;
        sd_req_o.block_addr = block_addr;
    end

    // capture strobe while read data is valid, header bytes only
    always_comb
    begin
        hdr_wr_o = '0;
        if (state == ST_RD_WAIT && !sd_busy_i && byte_idx < byte_idx_t'(HDR_BYTES))
            hdr_wr_o = hdr_wr_t'(1) << byte_idx;
    end

    assign uut_rst_o   = state != ST_RUN;
    assign uut_start_o = state == ST_RUN;
    assign timer_run_o = state == ST_RUN;
    assign timer_clr_o = state == ST_RUN_RST;
    assign hdr_clr_o   = state == ST_IDLE;
    assign load_byte_o = state == ST_WR_LOAD;
    assign halted_o    = state == ST_HALT;
    assign byte_idx_o  = byte_idx;
    assign iter_idx_o  = iter_idx;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= ST_IDLE;
            block_addr <= block_addr_t'(START_BLOCK);
            byte_idx   <= '0;
            iter_idx   <= '0;
        end
        else
        begin
            state <= state_nxt;

            if (state == ST_ADVANCE)
                block_addr <= block_addr + 1'b1;

            if (state == ST_IDLE || state == ST_CHECK)
                byte_idx <= '0;
            else if (byte_done && !last_byte)
                byte_idx <= byte_idx + 1'b1;

            if (state == ST_IDLE)
                iter_idx <= '0;
            else if (state == ST_RUN && run_done_i)
                iter_idx <= iter_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* rtl/tx_byte_sel.sv */
`default_nettype none

module tx_byte_sel #(
    parameter int MAX_ITER = autotest_pkg::DEF_MAX_ITER
) (
    input  logic                                  clk,
    input  logic                                  load_byte_i,
    input  autotest_pkg::byte_idx_t               byte_idx_i,
    input  logic [31:0]                           sig_i,
    input  autotest_pkg::iter_t                   iter_count_i,
    input  autotest_pkg::uut_cfg_t                uut_cfg_i,
    input  autotest_pkg::run_time_t [MAX_ITER-1:0] times_i,
    output autotest_pkg::sd_byte_t                sd_wdata_o
);
    import autotest_pkg::*;

    sd_byte_t  next_byte;
    byte_idx_t rel;
    iter_t     slot;
    iter_t     n_runs;

    assign n_runs = run_count(iter_count_i, MAX_ITER);

    // position relative to the first time byte with four bytes per slot
    assign rel  = byte_idx_i - byte_idx_t'(OFS_TIMES);
    assign slot = rel[9:2];

    always_comb
    begin
        next_byte = 8'hFF;
        case (byte_idx_i)
            byte_idx_t'(OFS_SIG):      next_byte = sig_i[31:24];
            byte_idx_t'(OFS_SIG + 1):  next_byte = sig_i[23:16];
            byte_idx_t'(OFS_SIG + 2):  next_byte = sig_i[15:8];
            byte_idx_t'(OFS_SIG + 3):  next_byte = sig_i[7:0];
            byte_idx_t'(OFS_ITER):     next_byte = iter_count_i;
            byte_idx_t'(OFS_NBLK):     next_byte = uut_cfg_i.n_blocks[7:0];
            byte_idx_t'(OFS_NBLK + 1): next_byte = uut_cfg_i.n_blocks[15:8];
            byte_idx_t'(OFS_SCLK):     next_byte = uut_cfg_i.sclk_speed;
            byte_idx_t'(OFS_CMD18):    next_byte = uut_cfg_i.cmd18;
            default:
                // unused slots stay 0xFF
                if (slot < n_runs)
                    next_byte = times_i[slot][{rel[1:0], 3'b000} +: 8];
        endcase
    end

    // held stable for the whole host byte transfer
    always_ff @(posedge clk)
    begin
        if (load_byte_i)
            sd_wdata_o <= next_byte;
    end

endmodule

`default_nettype wire

/* rtl/run_timer.sv */
`default_nettype none

module run_timer #(
    parameter int MAX_ITER       = autotest_pkg::DEF_MAX_ITER,
    parameter int TIMEOUT_CYCLES = autotest_pkg::DEF_TIMEOUT_CYCLES
) (
    input  logic                                  clk,
    input  logic                                  timer_clr_i,
    input  logic                                  timer_run_i,
    input  logic                                  uut_finish_i,
    input  autotest_pkg::iter_t                   iter_idx_i,
    output logic                                  run_done_o,
    output autotest_pkg::run_time_t [MAX_ITER-1:0] times_o
);
    import autotest_pkg::*;

    run_time_t count;
    logic      timed_out;

    assign timed_out = count == run_time_t'(TIMEOUT_CYCLES);

    // finish seen or count saturated
    assign run_done_o = timer_run_i && (uut_finish_i || timed_out);

    // one count per edge with start high and finish low
    always_ff @(posedge clk)
    begin
        if (timer_clr_i)
            count <= '0;
        else if (timer_run_i && !uut_finish_i && !timed_out)
            count <= count + 1'b1;
    end

    // result slot per iteration
    always_ff @(posedge clk)
    begin
        if (run_done_o && int'(iter_idx_i) < MAX_ITER)
            times_o[iter_idx_i] <= count;
    end

endmodule

`default_nettype wire

/* rtl/header_regs.sv */
`default_nettype none

module header_regs (
    input  logic                   clk,
    input  logic                   hdr_clr_i,
    input  autotest_pkg::hdr_wr_t  hdr_wr_i,
    input  autotest_pkg::sd_byte_t sd_rdata_i,
    output logic [31:0]            sig_o,
    output autotest_pkg::iter_t    iter_count_o,
    output autotest_pkg::uut_cfg_t uut_cfg_o,
    output logic                   sig_ok_o
);
    import autotest_pkg::*;

    always_ff @(posedge clk)
    begin
        if (hdr_clr_i)
        begin
            sig_o        <= '0;
            iter_count_o <= '0;
            uut_cfg_o    <= '0;
        end
        else
        begin
            // signature arrives msb first
            for (int k = 0; k < 4; k++)
            begin
                if (hdr_wr_i[OFS_SIG + k])
                    sig_o[8*(3-k) +: 8] <= sd_rdata_i;
            end

            if (hdr_wr_i[OFS_ITER])
                iter_count_o <= sd_rdata_i;

            // n_blocks is lsb first
            if (hdr_wr_i[OFS_NBLK])
                uut_cfg_o.n_blocks[7:0] <= sd_rdata_i;
            if (hdr_wr_i[OFS_NBLK + 1])
                uut_cfg_o.n_blocks[15:8] <= sd_rdata_i;

            if (hdr_wr_i[OFS_SCLK])
                uut_cfg_o.sclk_speed <= sd_rdata_i;
            if (hdr_wr_i[OFS_CMD18])
                uut_cfg_o.cmd18 <= sd_rdata_i;
        end
    end

    assign sig_ok_o = sig_o == SIGNATURE;

endmodule

`default_nettype wire

/* rtl/autotest_pkg.sv */
`default_nettype none

package autotest_pkg;

    // defaults for the top-level parameters
    localparam int DEF_START_BLOCK    = 0;
    localparam int DEF_MAX_ITER       = 4;
    localparam int DEF_TIMEOUT_CYCLES = 115343360;

    typedef logic [31:0] block_addr_t;
    typedef logic [7:0]  sd_byte_t;
    typedef logic [9:0]  byte_idx_t;
    typedef logic [31:0] run_time_t;
    typedef logic [7:0]  iter_t;

    localparam logic [31:0] SIGNATURE   = 32'hAABBCCDD;
    localparam int          BLOCK_BYTES = 512;

    // header layout inside a block
    localparam int OFS_SIG   = 0;
    localparam int OFS_ITER  = 4;
    localparam int OFS_NBLK  = 5;
    localparam int OFS_SCLK  = 7;
    localparam int OFS_CMD18 = 8;
    localparam int OFS_TIMES = 9;
    localparam int HDR_BYTES = OFS_TIMES;

    // one capture strobe per header byte
    typedef logic [HDR_BYTES-1:0] hdr_wr_t;

    typedef struct packed {
        logic [15:0] n_blocks;
        logic [7:0]  sclk_speed;
        logic [7:0]  cmd18;
    } uut_cfg_t;

    typedef struct packed {
        logic        r_block;
        logic        r_byte;
        logic        w_block;
        logic        w_byte;
        block_addr_t block_addr;
    } sd_req_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_RD_BLOCK,
        ST_RD_SEL,
        ST_RD_REQ,
        ST_RD_WAIT,
        ST_CHECK,
        ST_RUN_RST,
        ST_RUN,
        ST_WR_BLOCK,
        ST_WR_SEL,
        ST_WR_LOAD,
        ST_WR_REQ,
        ST_WR_WAIT,
        ST_ADVANCE,
        ST_HALT
    } ctrl_state_t;

    // runs actually executed, the header count capped by the slot count
    function automatic iter_t run_count(iter_t cnt, int max_iter);
        if (int'(cnt) > max_iter)
            return iter_t'(max_iter);
        return cnt;
    endfunction

endpackage

`default_nettype wire
